// File: compile.f
src/mips_pkg.sv
src/fetch_unit.sv
src/register_file.sv
src/hazard_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_pipeline.sv
tests/tb_mips_pipeline.sv

// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - src/mips_pkg.sv
  - src/fetch_unit.sv
  - src/register_file.sv
  - src/hazard_unit.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/mips_pipeline.sv
  - target: test
    files:
      - tests/tb_mips_pipeline.sv

// File: tests/tb_mips_pipeline.sv
//************************************************************
// directed testbench for the MIPS pipeline top level
// loads each program through the program port, reads results
//************************************************************
module tb_mips_pipeline;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int IMEM_DEPTH = 256;
    localparam int IA_W       = $clog2(IMEM_DEPTH);

    logic            SYS_clk;
    logic            SYS_reset;
    logic            prog_we;
    logic [IA_W-1:0] prog_addr;
    word_t           prog_data;
    reg_addr_t       dbg_addr;
    word_t           dbg_data;

    word_t  prog [$];  // program of the current test
    integer seed;
    int     errors;
    int     checks;

    mips_pipeline #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (256)
    ) u_mips_pipeline (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #10 SYS_clk = ~SYS_clk;
    end

    function automatic word_t r_format(input funct_e fn, input int rd, input int rs, input int rt);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fn)};
    endfunction

    function automatic word_t i_format(input opcode_e op, input int rt, input int rs,
                                       input logic [15:0] imm);
        return {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t signed_less(input word_t a, input word_t b);
        return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
    endfunction

    function automatic logic [15:0] random_imm();
        word_t r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // load / run time of one test, used for the timeout
    function automatic int test_cycles(input int n_instr, input int n_reads);
        return IMEM_DEPTH + 1 + 3 * n_instr + 10 + n_reads;
    endfunction

    task automatic push_spaced(input word_t instr);
        prog.push_back(instr);
        repeat (3) prog.push_back(NOP_INSTR);  // keeps neighbours independent
    endtask

    task automatic check_value(input string what, input word_t got, input word_t expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("** Error at %0t: %s read %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic expect_reg(input int r, input word_t expected);
        @(posedge SYS_clk);
        #2;
        dbg_addr = reg_addr_t'(r);
        #8;
        check_value($sformatf("register r%0d", r), dbg_data, expected);
    endtask

    // reset held during the load, unused words get a tagged unknown opcode
    task automatic run_program();
        int n;
        n = prog.size();
        for (int i = 0; i < IMEM_DEPTH; i++)
        begin
            @(posedge SYS_clk);
            #2;
            SYS_reset = 1'b1;
            prog_we   = 1'b1;
            prog_addr = i[IA_W-1:0];
            prog_data = (i < n) ? prog[i] : {6'h3f, 26'(i)};
        end
        @(posedge SYS_clk);
        #2;
        prog_we   = 1'b0;
        SYS_reset = 1'b0;
        repeat (3 * n + 10) @(posedge SYS_clk);
    endtask

    task automatic test_alu_ops();
        logic [15:0] ia;
        logic [15:0] ib;
        logic [15:0] ic;
        word_t       a;
        word_t       b;
        ia = random_imm() | 16'h8000;  // negative, so slt must compare signed
        ib = random_imm() & 16'h7fff;  // positive, a - b goes negative
        ic = random_imm();
        a  = sext(ia);
        b  = sext(ib);
        prog.delete();
        push_spaced(i_format(op_addi, 1, 0, ia));
        push_spaced(i_format(op_addi, 2, 0, ib));
        push_spaced(r_format(fn_add, 3, 1, 2));
        push_spaced(r_format(fn_sub, 4, 1, 2));
        push_spaced(r_format(fn_and, 5, 1, 2));
        push_spaced(r_format(fn_or, 6, 1, 2));
        push_spaced(r_format(fn_slt, 7, 1, 2));
        push_spaced(r_format(fn_slt, 8, 2, 1));
        push_spaced(i_format(op_addi, 9, 1, ic));
        run_program();
        expect_reg(1, a);
        expect_reg(2, b);
        expect_reg(3, a + b);
        expect_reg(4, a - b);
        expect_reg(5, a & b);
        expect_reg(6, a | b);
        expect_reg(7, signed_less(a, b));
        expect_reg(8, signed_less(b, a));
        expect_reg(9, a + sext(ic));
    endtask

    task automatic test_dependent_chain();
        logic [15:0] ix;
        logic [15:0] iy;
        word_t       r [1:8];
        ix   = random_imm();
        iy   = random_imm();
        r[1] = sext(ix);  // same chain executed in order
        r[2] = r[1] + sext(iy);
        r[3] = r[1] + r[2];
        r[4] = r[1] - r[3];
        r[5] = r[4] | r[2];
        r[6] = r[5] & r[3];
        r[7] = signed_less(r[4], r[6]);
        r[8] = r[7] + r[6];
        prog.delete();
        prog.push_back(i_format(op_addi, 1, 0, ix));
        prog.push_back(i_format(op_addi, 2, 1, iy));
        prog.push_back(r_format(fn_add, 3, 1, 2));
        prog.push_back(r_format(fn_sub, 4, 1, 3));
        prog.push_back(r_format(fn_or, 5, 4, 2));
        prog.push_back(r_format(fn_and, 6, 5, 3));
        prog.push_back(r_format(fn_slt, 7, 4, 6));
        prog.push_back(r_format(fn_add, 8, 7, 6));
        run_program();
        for (int i = 1; i <= 8; i++)
        begin
            expect_reg(i, r[i]);
        end
    endtask

    task automatic test_load_use();
        logic [15:0] ival;
        logic [15:0] iother;
        logic [15:0] iaddr;
        ival   = random_imm();
        iother = random_imm();
        iaddr  = random_imm() & 16'h00fc;  // word aligned base
        prog.delete();
        prog.push_back(i_format(op_addi, 1, 0, ival));
        prog.push_back(i_format(op_addi, 2, 0, iaddr));
        prog.push_back(i_format(op_addi, 3, 0, iother));
        prog.push_back(i_format(op_sw, 1, 2, 16'd4));
        prog.push_back(i_format(op_lw, 4, 2, 16'd4));
        prog.push_back(r_format(fn_add, 5, 4, 3));  // uses the load right away
        run_program();
        expect_reg(4, sext(ival));
        expect_reg(5, sext(ival) + sext(iother));
    endtask

    task automatic test_branches();
        prog.delete();
        prog.push_back(i_format(op_addi, 1, 0, 16'd3));
        prog.push_back(i_format(op_addi, 2, 0, 16'd3));
        prog.push_back(i_format(op_addi, 3, 0, 16'd4));
        prog.push_back(i_format(op_beq, 2, 1, 16'd2));  // taken
        prog.push_back(i_format(op_addi, 10, 0, 16'd10));
        prog.push_back(i_format(op_addi, 11, 0, 16'd11));
        prog.push_back(i_format(op_addi, 12, 0, 16'd12));
        prog.push_back(i_format(op_beq, 3, 1, 16'd2));  // not taken
        prog.push_back(i_format(op_addi, 13, 0, 16'd13));
        prog.push_back(i_format(op_addi, 14, 0, 16'd14));
        prog.push_back(i_format(op_addi, 15, 0, 16'd15));
        prog.push_back(i_format(op_bne, 3, 1, 16'd2));  // taken
        prog.push_back(i_format(op_addi, 16, 0, 16'd16));
        prog.push_back(i_format(op_addi, 17, 0, 16'd17));
        prog.push_back(i_format(op_addi, 18, 0, 16'd18));
        prog.push_back(i_format(op_bne, 2, 1, 16'd2));  // not taken
        prog.push_back(i_format(op_addi, 19, 0, 16'd19));
        prog.push_back(i_format(op_addi, 20, 0, 16'd20));
        prog.push_back(i_format(op_addi, 21, 0, 16'd21));
        run_program();
        // only the two instructions jumped over stay at zero
        for (int r = 10; r <= 21; r++)
        begin
            expect_reg(r, (r == 11 || r == 17) ? word_t'(0) : word_t'(r));
        end
    endtask

    task automatic test_zero_register();
        prog.delete();
        prog.push_back(i_format(op_addi, 1, 0, 16'd77));
        prog.push_back(i_format(op_addi, 0, 0, 16'd123));
        prog.push_back(r_format(fn_add, 5, 0, 1));
        prog.push_back(r_format(fn_add, 0, 1, 1));
        prog.push_back(r_format(fn_or, 6, 0, 1));
        run_program();
        expect_reg(0, '0);
        expect_reg(5, word_t'(77));
        expect_reg(6, word_t'(77));
        prog.delete();
        run_program();  // second reset with an empty program
        for (int r = 0; r < NUM_REGS; r++)
        begin
            expect_reg(r, '0);
        end
    endtask

    initial
    begin
        int limit;
        int cycle_count;
        limit = 4 + 200 + test_cycles(36, 9) + test_cycles(8, 8) + test_cycles(6, 2)
                + test_cycles(19, 12) + test_cycles(5, 3) + test_cycles(0, 32);
        cycle_count = 0;
        while (cycle_count < limit)
        begin
            @(posedge SYS_clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        seed      = 44969;
        errors    = 0;
        checks    = 0;
        SYS_reset = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        repeat (4) @(posedge SYS_clk);
        #2;
        SYS_reset = 1'b0;
        test_alu_ops();
        test_dependent_chain();
        test_load_use();
        test_branches();
        test_zero_register();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src/mips_pipeline.sv
//**********************************************************
// five-stage MIPS subset pipeline top level
// sets the memory depths and wires the stages by name
//**********************************************************
module mips_pipeline #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          SYS_clk,
    input  logic                          SYS_reset,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  mips_pkg::word_t               prog_data,
    input  mips_pkg::reg_addr_t           dbg_addr,
    output mips_pkg::word_t               dbg_data
);
    import mips_pkg::*;

    word_t     pc;  // fetch outputs
    word_t     instr;
    word_t     branch_target;
    logic      branch_taken;
    logic      stall;
    logic      fwd_a;
    logic      fwd_b;
    reg_addr_t d_rs;
    reg_addr_t d_rt;
    logic      d_uses_rs;
    logic      d_uses_rt;
    word_t     a_val;
    word_t     b_val;
    word_t     imm;
    reg_addr_t dest;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    logic      alu_src_imm;
    alu_op_e   alu_op;
    reg_addr_t ex_dest;
    logic      ex_reg_write;
    logic      ex_mem_read;
    logic      ex_mem_write;
    logic      ex_mem_to_reg;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t mem_dest;
    logic      mem_reg_write;
    logic      mem_mem_read;
    word_t     mem_alu_result;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch_unit (.*);

    decode_stage u_decode_stage (
        .f_pc    (pc),
        .f_instr (instr),
        .*
    );

    hazard_unit u_hazard_unit (.*);

    execute_stage u_execute_stage (.*);

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory_stage (.*);

endmodule

// File: src/memory_stage.sv
//**********************************************************
// memory and writeback registers with the data memory
// DMEM_DEPTH is expected to be a power of two
//**********************************************************
module memory_stage #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_mem_to_reg,
    input  mips_pkg::word_t     alu_result,
    input  mips_pkg::word_t     store_data,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_reg_write,
    output logic                mem_mem_read,
    output mips_pkg::word_t     mem_alu_result,
    output logic                wb_we,
    output mips_pkg::reg_addr_t wb_addr,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    localparam int DA_W = $clog2(DMEM_DEPTH);

    word_t dmem [DMEM_DEPTH];
    logic  mem_mem_write;
    logic  mem_mem_to_reg;
    word_t mem_store_data;
    word_t mem_read_data;
    logic  wb_mem_to_reg;
    word_t wb_read_data;
    word_t wb_alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_dest       <= '0;
            mem_reg_write  <= 1'b0;
            mem_mem_read   <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
            wb_we          <= 1'b0;
            wb_addr        <= '0;
            wb_mem_to_reg  <= 1'b0;
        end
        else
        begin
            mem_dest       <= ex_dest;
            mem_reg_write  <= ex_reg_write;
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_mem_to_reg <= ex_mem_to_reg;
            wb_we          <= mem_reg_write;
            wb_addr        <= mem_dest;
            wb_mem_to_reg  <= mem_mem_to_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_result <= alu_result;
        mem_store_data <= store_data;
        wb_alu_result  <= mem_alu_result;
        wb_read_data   <= mem_read_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (mem_mem_write)
        begin
            dmem[mem_alu_result[DA_W+1:2]] <= mem_store_data;
        end
    end

    assign mem_read_data = dmem[mem_alu_result[DA_W+1:2]];  // async read
    assign wb_data       = wb_mem_to_reg ? wb_read_data : wb_alu_result;

endmodule

// File: src/execute_stage.sv
//**********************************************************
// execute register and ALU
// a stall from decode loads a bubble into this stage
//**********************************************************
module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  mips_pkg::word_t     a_val,
    input  mips_pkg::word_t     b_val,
    input  mips_pkg::word_t     imm,
    input  mips_pkg::reg_addr_t dest,
    input  logic                reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                mem_to_reg,
    input  logic                alu_src_imm,
    input  mips_pkg::alu_op_e   alu_op,
    output mips_pkg::reg_addr_t ex_dest,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output logic                ex_mem_to_reg,
    output mips_pkg::word_t     alu_result,
    output mips_pkg::word_t     store_data
);
    import mips_pkg::*;

    word_t   ex_a;
    word_t   ex_imm;
    logic    ex_alu_src_imm;
    alu_op_e ex_alu_op;
    word_t   op_b;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)  // bubble on stall
        begin
            ex_dest       <= '0;
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
        end
        else
        begin
            ex_dest       <= dest;
            ex_reg_write  <= reg_write;
            ex_mem_read   <= mem_read;
            ex_mem_write  <= mem_write;
            ex_mem_to_reg <= mem_to_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_a           <= a_val;
        store_data     <= b_val;  // rt value for sw
        ex_imm         <= imm;
        ex_alu_src_imm <= alu_src_imm;
        ex_alu_op      <= alu_op;
    end

    assign op_b = ex_alu_src_imm ? ex_imm : store_data;

    always_comb
    begin
        case (ex_alu_op)
            alu_add: alu_result = ex_a + op_b;
            alu_sub: alu_result = ex_a - op_b;
            alu_and: alu_result = ex_a & op_b;
            alu_or:  alu_result = ex_a | op_b;
            alu_slt: alu_result = word_t'($signed(ex_a) < $signed(op_b));
            default: alu_result = '0;
        endcase
    end

endmodule

// File: src/decode_stage.sv
//**********************************************************
// decode register, control decode and operand read
// branches resolve here and redirect fetch next cycle
//**********************************************************
module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  mips_pkg::word_t     f_pc,
    input  mips_pkg::word_t     f_instr,
    input  logic                fwd_a,
    input  logic                fwd_b,
    input  mips_pkg::word_t     mem_alu_result,
    input  logic                wb_we,
    input  mips_pkg::reg_addr_t wb_addr,
    input  mips_pkg::word_t     wb_data,
    input  mips_pkg::reg_addr_t dbg_addr,
    output mips_pkg::word_t     dbg_data,
    output mips_pkg::reg_addr_t d_rs,
    output mips_pkg::reg_addr_t d_rt,
    output logic                d_uses_rs,
    output logic                d_uses_rt,
    output mips_pkg::word_t     a_val,
    output mips_pkg::word_t     b_val,
    output mips_pkg::word_t     imm,
    output mips_pkg::reg_addr_t dest,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                mem_to_reg,
    output logic                alu_src_imm,
    output mips_pkg::alu_op_e   alu_op,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target
);
    import mips_pkg::*;

    word_t   d_instr;
    word_t   d_pc;
    opcode_e opcode;
    funct_e  funct;
    word_t   rs_data;
    word_t   rt_data;
    logic    is_beq;
    logic    is_bne;
    logic    dest_is_rd;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            d_instr <= NOP_INSTR;
            d_pc    <= '0;
        end
        else if (!stall)
        begin
            d_instr <= f_instr;
            d_pc    <= f_pc;
        end
    end

    assign opcode = opcode_e'(d_instr[31:26]);
    assign funct  = funct_e'(d_instr[5:0]);
    assign d_rs   = d_instr[25:21];
    assign d_rt   = d_instr[20:16];
    assign dest   = dest_is_rd ? d_instr[15:11] : d_rt;  // rd for R-type
    assign imm    = {{16{d_instr[15]}}, d_instr[15:0]};

    always_comb
    begin
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        alu_src_imm = 1'b0;
        alu_op      = alu_add;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        dest_is_rd  = 1'b0;
        d_uses_rs   = 1'b1;
        d_uses_rt   = 1'b0;
        case (opcode)
            op_rtype:
            begin
                reg_write  = 1'b1;
                dest_is_rd = 1'b1;
                d_uses_rt  = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: reg_write = 1'b0;  // unsupported funct as nop
                endcase
            end
            op_addi:
            begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            op_lw:
            begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                mem_to_reg  = 1'b1;
                alu_src_imm = 1'b1;
            end
            op_sw:
            begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                d_uses_rt   = 1'b1;
            end
            op_beq:
            begin
                is_beq    = 1'b1;
                d_uses_rt = 1'b1;
            end
            op_bne:
            begin
                is_bne    = 1'b1;
                d_uses_rt = 1'b1;
            end
            default: d_uses_rs = 1'b0;  // unknown opcode reads nothing
        endcase
    end

    register_file u_register_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (d_rs),
        .rt_addr   (d_rt),
        .dbg_addr  (dbg_addr),
        .we        (wb_we),
        .waddr     (wb_addr),
        .wdata     (wb_data),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .dbg_data  (dbg_data)
    );

    assign a_val = fwd_a ? mem_alu_result : rs_data;  // forward from memory stage
    assign b_val = fwd_b ? mem_alu_result : rt_data;

    assign branch_taken  = (is_beq && (a_val == b_val)) || (is_bne && (a_val != b_val));
    assign branch_target = d_pc + word_t'(4) + (imm << 2);

endmodule

// File: src/hazard_unit.sv
//**********************************************************
// stall and forward select for the decode stage
// compares decode sources against execute and memory dests
//**********************************************************
module hazard_unit (
    input  mips_pkg::reg_addr_t d_rs,
    input  mips_pkg::reg_addr_t d_rt,
    input  logic                d_uses_rs,
    input  logic                d_uses_rt,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_reg_write,
    input  logic                mem_mem_read,
    output logic                stall,
    output logic                fwd_a,
    output logic                fwd_b
);
    import mips_pkg::*;

    logic ex_pending;   // execute result not ready for decode
    logic mem_load;     // load data only ready in writeback
    logic mem_alu;      // ALU result available for forwarding
    logic ex_hit;
    logic mem_hit;

    // a source matches a live nonzero destination
    function automatic logic reads_dest(input reg_addr_t src,
                                        input logic      uses,
                                        input reg_addr_t dst);
        return uses && (dst != '0) && (src == dst);
    endfunction

    assign ex_pending = ex_reg_write || ex_mem_read;
    assign mem_load   = mem_reg_write && mem_mem_read;
    assign mem_alu    = mem_reg_write && !mem_mem_read;

    assign ex_hit  = ex_pending &&
                     (reads_dest(d_rs, d_uses_rs, ex_dest) ||
                      reads_dest(d_rt, d_uses_rt, ex_dest));
    assign mem_hit = mem_load &&
                     (reads_dest(d_rs, d_uses_rs, mem_dest) ||
                      reads_dest(d_rt, d_uses_rt, mem_dest));

    // ALU producer costs 1 cycle, a load costs 2
    assign stall = ex_hit || mem_hit;

    assign fwd_a = mem_alu && reads_dest(d_rs, 1'b1, mem_dest);
    assign fwd_b = mem_alu && reads_dest(d_rt, 1'b1, mem_dest);

endmodule

// File: src/register_file.sv
//**********************************************************
// 32 x 32 register file with write-through reads
// r0 is never written and reads zero
//**********************************************************
module register_file (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t dbg_addr,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     dbg_data
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_live;

    assign wr_live = we && (waddr != '0);  // drop writes to r0

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_live)
        begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle writeback goes straight to the read ports
    assign rs_data  = (wr_live && waddr == rs_addr) ? wdata : regs[rs_addr];
    assign rt_data  = (wr_live && waddr == rt_addr) ? wdata : regs[rt_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

// File: src/fetch_unit.sv
//**********************************************************
// program counter and instruction memory
// program words are written through prog_we / prog_addr
//**********************************************************
module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          SYS_clk,
    input  logic                          SYS_reset,
    input  logic                          stall,
    input  logic                          branch_taken,
    input  mips_pkg::word_t               branch_target,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  mips_pkg::word_t               prog_data,
    output mips_pkg::word_t               pc,
    output mips_pkg::word_t               instr
);
    import mips_pkg::*;

    localparam int IA_W = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t next_pc;

    always_ff @(posedge SYS_clk)
    begin
        if (prog_we)
        begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign instr   = imem[pc[IA_W+1:2]];  // word address, wraps at depth
    assign next_pc = branch_taken ? branch_target : pc + word_t'(4);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc <= '0;
        end
        else if (!stall)  // hold while decode waits
        begin
            pc <= next_pc;
        end
    end

endmodule

// File: src/mips_pkg.sv
//**********************************************************
// shared widths, types and encodings of the MIPS pipeline
// each module imports this package in its body
//**********************************************************
package mips_pkg;

    localparam int XLEN       = 32;  // data and instruction width
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'd0,
        op_beq   = 6'd4,
        op_bne   = 6'd5,
        op_addi  = 6'd8,
        op_lw    = 6'd35,
        op_sw    = 6'd43
    } opcode_e;

    // funct field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        fn_add = 6'd32,
        fn_sub = 6'd34,
        fn_and = 6'd36,
        fn_or  = 6'd37,
        fn_slt = 6'd42
    } funct_e;

    // operation selected in the execute stage
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt  // signed compare
    } alu_op_e;

    // sll r0,r0,0 which decodes as a bubble
    localparam word_t NOP_INSTR = '0;

endpackage
